//--- hdl/bp_pkg.sv
package bp_pkg;

  // table geometry
  localparam int num_banks        = 4;
  localparam int bank_bits        = 2;
  localparam int entries_per_bank = 16;
  localparam int entry_bits       = 4;

  // pc bit positions for bank and entry slices
  localparam int bank_lsb  = 2;
  localparam int entry_lsb = bank_lsb + bank_bits;

  typedef logic [63:0]           pc_t;         // byte address
  typedef logic [31:0]           inst_t;       // instruction word
  typedef logic [5:0]            opcode_t;     // inst bits 31:26
  typedef logic [bank_bits-1:0]  bank_sel_t;
  typedef logic [entry_bits-1:0] entry_idx_t;
  typedef logic [1:0]            counter_t;    // 2-bit saturating counter

  localparam counter_t counter_reset = 2'b01;  // weakly not taken
  localparam counter_t counter_max   = 2'b11;
  localparam counter_t counter_min   = 2'b00;

  // conditional branches
  localparam opcode_t op_blbc = 6'h38;
  localparam opcode_t op_beq  = 6'h39;
  localparam opcode_t op_blt  = 6'h3a;
  localparam opcode_t op_ble  = 6'h3b;
  localparam opcode_t op_blbs = 6'h3c;
  localparam opcode_t op_bne  = 6'h3d;
  localparam opcode_t op_bge  = 6'h3e;
  localparam opcode_t op_bgt  = 6'h3f;

  // unconditional branches
  localparam opcode_t op_br      = 6'h30;
  localparam opcode_t op_bsr     = 6'h34;
  localparam opcode_t op_jsr_grp = 6'h1a;  // jmp, jsr, ret, jsr_co

  typedef struct packed {
    pc_t   pc;
    inst_t inst;
    logic  valid;
  } fetch_req_t;

  // resolved branch from the functional unit
  typedef struct packed {
    logic valid;
    pc_t  pc;
    logic taken;
    pc_t  target;
    logic is_cond;
    logic rollback;   // mispredict, redirect fetch to target
  } resolve_t;

  // write payload shared by all banks
  typedef struct packed {
    entry_idx_t idx;
    logic       taken;
    logic       is_cond;
    pc_t        target;
  } bank_update_t;

  typedef struct packed {
    logic hit;          // entry valid bit
    logic counter_msb;
    pc_t  target;
  } bank_resp_t;

  typedef struct packed {
    logic taken;
    pc_t  next_pc;
  } prediction_t;

endpackage

//--- hdl/branch_decode.sv
`timescale 1ns/1ps

module branch_decode (
  input  bp_pkg::fetch_req_t           fetch_req,
  input  bp_pkg::resolve_t             resolve,
  output bp_pkg::entry_idx_t           lookup_idx,
  output bp_pkg::bank_sel_t            lookup_bank,
  output logic                         is_cond,
  output logic                         is_uncond,
  output bp_pkg::bank_update_t         update,
  output logic [bp_pkg::num_banks-1:0] update_en
);

  bp_pkg::opcode_t   opcode;
  bp_pkg::bank_sel_t resolve_bank;

  assign opcode = fetch_req.inst[31:26];

  // fetch side index, pc bits 7:4 pick the entry and 3:2 the bank
  assign lookup_idx  = fetch_req.pc[bp_pkg::entry_lsb +: bp_pkg::entry_bits];
  assign lookup_bank = fetch_req.pc[bp_pkg::bank_lsb +: bp_pkg::bank_bits];

  // branch class of the fetched instruction
  always_comb begin
    is_cond   = 1'b0;
    is_uncond = 1'b0;
    if (fetch_req.valid) begin
      case (opcode)
        bp_pkg::op_blbc,
        bp_pkg::op_beq,
        bp_pkg::op_blt,
        bp_pkg::op_ble,
        bp_pkg::op_blbs,
        bp_pkg::op_bne,
        bp_pkg::op_bge,
        bp_pkg::op_bgt: begin
          is_cond = 1'b1;
        end
        bp_pkg::op_br,
        bp_pkg::op_bsr,
        bp_pkg::op_jsr_grp: begin  // jsr group handled like br
          is_uncond = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // resolve side slices
  assign resolve_bank = resolve.pc[bp_pkg::bank_lsb +: bp_pkg::bank_bits];

  assign update.idx     = resolve.pc[bp_pkg::entry_lsb +: bp_pkg::entry_bits];
  assign update.taken   = resolve.taken;
  assign update.is_cond = resolve.is_cond;
  assign update.target  = resolve.target;

  // one-hot write enable, only the owning bank trains
  always_comb begin
    update_en = '0;
    if (resolve.valid) begin
      update_en[resolve_bank] = 1'b1;
    end
  end

endmodule

//--- hdl/predictor_bank.sv
`timescale 1ns/1ps

module predictor_bank (
  input  logic                 clock,
  input  logic                 reset,
  input  bp_pkg::entry_idx_t   lookup_idx,
  input  bp_pkg::bank_update_t update,
  input  logic                 update_en,
  output bp_pkg::bank_resp_t   resp
);

  // per-entry state
  bp_pkg::counter_t                    counters [bp_pkg::entries_per_bank];
  bp_pkg::pc_t                         targets  [bp_pkg::entries_per_bank];
  logic [bp_pkg::entries_per_bank-1:0] valids;

  bp_pkg::counter_t cur_count;
  bp_pkg::counter_t next_count;
  logic             write_counter;
  logic             write_target;

  // lookup is a plain combinational read, no bypass from the write port
  assign resp.hit         = valids[lookup_idx];
  assign resp.counter_msb = counters[lookup_idx][1];
  assign resp.target      = targets[lookup_idx];

  assign cur_count = counters[update.idx];

  // saturating step
  always_comb begin
    next_count = cur_count;
    if (update.taken) begin
      if (cur_count != bp_pkg::counter_max) begin
        next_count = cur_count + 2'd1;
      end
    end else begin
      if (cur_count != bp_pkg::counter_min) begin
        next_count = cur_count - 2'd1;
      end
    end
  end

  // only conditional resolves move the counter
  assign write_counter = update_en && update.is_cond;

  // any taken resolve installs the target
  assign write_target = update_en && update.taken;

  always_ff @(posedge clock) begin
    if (reset) begin
      counters <= '{default: bp_pkg::counter_reset};
    end else if (write_counter) begin
      counters[update.idx] <= next_count;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      targets <= '{default: '0};
    end else if (write_target) begin
      targets[update.idx] <= update.target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valids <= '0;   // nothing predicts taken until trained
    end else if (write_target) begin
      valids[update.idx] <= 1'b1;
    end
  end

endmodule

//--- hdl/next_pc_select.sv
`timescale 1ns/1ps

module next_pc_select (
  input  bp_pkg::pc_t         fetch_pc,
  input  bp_pkg::bank_sel_t   lookup_bank,
  input  logic                is_cond,
  input  logic                is_uncond,
  input  bp_pkg::bank_resp_t  bank_resps [bp_pkg::num_banks],
  input  bp_pkg::resolve_t    resolve,
  output bp_pkg::prediction_t prediction
);

  bp_pkg::bank_resp_t sel_resp;
  bp_pkg::pc_t        fall_through;
  logic               predict_taken;
  logic               do_rollback;

  // response of the bank that owns this pc
  assign sel_resp = bank_resps[lookup_bank];

  assign fall_through = fetch_pc + 64'd4;

  // counter only matters for conditional branches
  assign predict_taken = sel_resp.hit &&
                         (is_uncond || (is_cond && sel_resp.counter_msb));

  assign do_rollback = resolve.valid && resolve.rollback;

  always_comb begin
    if (do_rollback) begin
      // redirect wins over whatever fetch is looking at
      prediction.taken   = 1'b1;
      prediction.next_pc = resolve.target;
    end else if (predict_taken) begin
      prediction.taken   = 1'b1;
      prediction.next_pc = sel_resp.target;
    end else begin
      prediction.taken   = 1'b0;
      prediction.next_pc = fall_through;
    end
  end

endmodule

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
  input  logic                clock,
  input  logic                reset,
  input  bp_pkg::fetch_req_t  fetch_req,
  input  bp_pkg::resolve_t    resolve,
  output bp_pkg::prediction_t prediction
);

  bp_pkg::entry_idx_t           lookup_idx;
  bp_pkg::bank_sel_t            lookup_bank;
  logic                         is_cond;
  logic                         is_uncond;
  bp_pkg::bank_update_t         update;
  logic [bp_pkg::num_banks-1:0] update_en;
  bp_pkg::bank_resp_t           bank_resps [bp_pkg::num_banks];

  // opcode class and pc slicing for both ports
  branch_decode u_decode (
    .fetch_req   (fetch_req),
    .resolve     (resolve),
    .lookup_idx  (lookup_idx),
    .lookup_bank (lookup_bank),
    .is_cond     (is_cond),
    .is_uncond   (is_uncond),
    .update      (update),
    .update_en   (update_en)
  );

  // all banks read the same index, the selector picks one
  for (genvar b = 0; b < bp_pkg::num_banks; b++) begin : g_bank
    predictor_bank u_bank (
      .clock      (clock),
      .reset      (reset),
      .lookup_idx (lookup_idx),
      .update     (update),
      .update_en  (update_en[b]),
      .resp       (bank_resps[b])
    );
  end

  next_pc_select u_select (
    .fetch_pc    (fetch_req.pc),
    .lookup_bank (lookup_bank),
    .is_cond     (is_cond),
    .is_uncond   (is_uncond),
    .bank_resps  (bank_resps),
    .resolve     (resolve),
    .prediction  (prediction)   // same-cycle answer to fetch
  );

endmodule

//--- dv/bp_ref.svh
`ifndef BP_REF_SVH
`define BP_REF_SVH

// shadow copy of the whole table, flat index is pc bits 7:2
bp_pkg::counter_t shadow_count  [64];
bp_pkg::pc_t      shadow_target [64];
logic             shadow_valid  [64];

task automatic clear_shadow();
  for (int i = 0; i < 64; i++) begin
    shadow_count[i]  = bp_pkg::counter_reset;
    shadow_target[i] = '0;
    shadow_valid[i]  = 1'b0;
  end
endtask

// one resolved branch, applied at the clock edge
task automatic train_shadow(input bp_pkg::resolve_t r);
  logic [5:0] i;
  i = r.pc[7:2];
  if (r.is_cond) begin
    if (r.taken && shadow_count[i] != 2'b11) begin
      shadow_count[i] = shadow_count[i] + 2'd1;
    end else if (!r.taken && shadow_count[i] != 2'b00) begin
      shadow_count[i] = shadow_count[i] - 2'd1;
    end
  end
  if (r.taken) begin   // any kind of branch
    shadow_target[i] = r.target;
    shadow_valid[i]  = 1'b1;
  end
endtask

function automatic bp_pkg::prediction_t expected_prediction(
  input bp_pkg::fetch_req_t f,
  input bp_pkg::resolve_t   r
);
  bp_pkg::prediction_t p;
  logic [5:0]          op;
  logic [5:0]          i;
  logic                cond;
  logic                uncond;
  op     = f.inst[31:26];
  i      = f.pc[7:2];
  cond   = f.valid && (op >= 6'h38);   // blbc through bgt
  uncond = f.valid && (op == 6'h30 || op == 6'h34 || op == 6'h1a);
  if (r.valid && r.rollback) begin
    p.taken   = 1'b1;
    p.next_pc = r.target;
  end else if (shadow_valid[i] && (uncond || (cond && shadow_count[i][1]))) begin
    p.taken   = 1'b1;
    p.next_pc = shadow_target[i];
  end else begin
    p.taken   = 1'b0;
    p.next_pc = f.pc + 64'd4;
  end
  return p;
endfunction

`endif

//--- dv/bp_tb.sv
`timescale 1ns/1ps

module bp_tb;

  localparam int reset_cycles    = 3;
  localparam int directed_cycles = 60;   // bound on the directed phases
  localparam int random_cycles   = 400;
  localparam int timeout_ns =
    (reset_cycles + directed_cycles + random_cycles) * 10 + 200;

  // eleven branches first and then non-branch opcodes
  localparam bp_pkg::opcode_t op_pool [16] = '{
    6'h38, 6'h39, 6'h3a, 6'h3b, 6'h3c, 6'h3d, 6'h3e, 6'h3f,
    6'h30, 6'h34, 6'h1a, 6'h10, 6'h11, 6'h29, 6'h08, 6'h2c
  };

  // br, bsr and jsr group pcs in banks 1 to 3
  localparam bp_pkg::pc_t pc_u  [3] = '{64'h2000_0104, 64'h2000_0128, 64'h2000_01fc};
  localparam bp_pkg::pc_t tgt_u [3] = '{64'h2000_8000, 64'h2000_9040, 64'h2000_a0fc};

  logic                clock;
  logic                reset;
  bp_pkg::fetch_req_t  fetch_req;
  bp_pkg::resolve_t    resolve;
  bp_pkg::prediction_t prediction;
  bp_pkg::prediction_t expected;

  integer seed;
  int     errors;
  int     checks;

  `include "bp_ref.svh"

  branch_predictor UUT (
    .clock      (clock),
    .reset      (reset),
    .fetch_req  (fetch_req),
    .resolve    (resolve),
    .prediction (prediction)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  function automatic bp_pkg::fetch_req_t fetch_item(
    input bp_pkg::pc_t     pc,
    input bp_pkg::opcode_t op,
    input logic            valid
  );
    bp_pkg::fetch_req_t f;
    f.pc    = pc;
    f.inst  = {op, 26'h2a5_1c3};   // low bits don't matter
    f.valid = valid;
    return f;
  endfunction

  function automatic bp_pkg::resolve_t resolve_item(
    input bp_pkg::pc_t pc,
    input logic        taken,
    input bp_pkg::pc_t target,
    input logic        is_cond,
    input logic        rollback
  );
    bp_pkg::resolve_t r;
    r.valid    = 1'b1;
    r.pc       = pc;
    r.taken    = taken;
    r.target   = target;
    r.is_cond  = is_cond;
    r.rollback = rollback;
    return r;
  endfunction

  // few entries with aliases above bit 7 in all four banks
  function automatic bp_pkg::pc_t mixed_pc(input logic [9:0] b);
    return 64'h0000_0001_2000_0000 | {54'h0, b[9:8], 2'b00, b[5:2], 2'b00};
  endfunction

  task automatic step(input bp_pkg::fetch_req_t f, input bp_pkg::resolve_t r);
    @(posedge clock);
    #1;
    fetch_req = f;
    resolve   = r;
  endtask

  // shadow tables follow the same edge as the banks
  always @(posedge clock) begin
    if (reset) begin
      clear_shadow();
    end else if (resolve.valid) begin
      train_shadow(resolve);
    end
  end

  // compare mid-cycle while inputs are stable
  always @(negedge clock) begin
    if (!reset) begin
      expected = expected_prediction(fetch_req, resolve);
      checks++;
      if (prediction !== expected) begin
        errors++;
        $display("mismatch at %0t: pc %h got %b %h expected %b %h", $time,
                 fetch_req.pc, prediction.taken, prediction.next_pc,
                 expected.taken, expected.next_pc);
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("timeout: stimulus still running after %0d ns", timeout_ns);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    bp_pkg::pc_t        pc_a;
    bp_pkg::pc_t        tgt_a;
    bp_pkg::pc_t        pc_r;
    bp_pkg::pc_t        tgt_r;
    bp_pkg::fetch_req_t f;
    bp_pkg::resolve_t   r;
    logic [31:0]        rand_fetch;
    logic [31:0]        rand_res;
    logic [31:0]        rand_tgt;
    reset     = 1'b1;
    fetch_req = '0;
    resolve   = '0;
    seed      = 32'h5944;
    errors    = 0;
    checks    = 0;
    pc_a      = 64'h1000_0040;
    tgt_a     = 64'h1000_4000;
    pc_r      = 64'h3000_0050;
    tgt_r     = 64'h3000_0800;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    // every branch falls through on the untrained table
    for (int k = 0; k < 11; k++) begin
      step(fetch_item(64'h1000 + 64'(k * 4), op_pool[k], 1'b1), '0);
      step(fetch_item(64'hffff_0000_0000_00f0 + 64'(k * 4), op_pool[k], 1'b1), '0);
    end

    // walk the counter up to strong taken, down to strong not taken and back up
    for (int k = 0; k < 4; k++) begin
      step(fetch_item(pc_a, 6'h39, 1'b1), resolve_item(pc_a, 1'b1, tgt_a, 1'b1, 1'b0));
    end
    for (int k = 0; k < 5; k++) begin
      step(fetch_item(pc_a, 6'h39, 1'b1), resolve_item(pc_a, 1'b0, tgt_a, 1'b1, 1'b0));
    end
    for (int k = 0; k < 2; k++) begin
      step(fetch_item(pc_a, 6'h39, 1'b1), resolve_item(pc_a, 1'b1, tgt_a, 1'b1, 1'b0));
    end
    step(fetch_item(pc_a, 6'h39, 1'b1), '0);

    // unconditional branches where the same-cycle fetch still sees the old entry
    for (int k = 0; k < 3; k++) begin
      step(fetch_item(pc_u[k], op_pool[8 + k], 1'b1),
           resolve_item(pc_u[k], 1'b1, tgt_u[k], 1'b0, 1'b0));
      step(fetch_item(pc_u[k], op_pool[8 + k], 1'b1), '0);
    end
    step('0, resolve_item(pc_u[0], 1'b0, 64'h0, 1'b0, 1'b0));
    step(fetch_item(pc_u[0], 6'h30, 1'b1), '0);

    // trained entries but no branch to predict
    step(fetch_item(pc_a, 6'h10, 1'b1), '0);
    step(fetch_item(pc_a, 6'h39, 1'b0), '0);
    step(fetch_item(pc_u[1], 6'h11, 1'b1), '0);

    // rollback redirects and trains in the same cycle
    step(fetch_item(64'h10, 6'h08, 1'b1), resolve_item(pc_r, 1'b1, tgt_r, 1'b1, 1'b1));
    step(fetch_item(pc_r, 6'h3e, 1'b1), '0);
    step(fetch_item(pc_r, 6'h3e, 1'b0),
         resolve_item(pc_a, 1'b0, pc_a + 64'd4, 1'b1, 1'b1));

    for (int n = 0; n < random_cycles; n++) begin
      rand_fetch = $random(seed);
      rand_res   = $random(seed);
      rand_tgt   = $random(seed);
      f = fetch_item(mixed_pc(rand_fetch[9:0]), op_pool[rand_fetch[15:12]],
                     rand_fetch[18:16] != 3'b000);
      r = resolve_item(mixed_pc(rand_res[9:0]), rand_res[12],
                       {32'h8000_0000, rand_tgt[31:2], 2'b00},
                       rand_res[13], rand_res[16:14] == 3'b000);
      r.valid = rand_res[17];
      step(f, r);
    end

    step('0, '0);
    @(posedge clock);   // last compare is done by now
    #1;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+dv
hdl/bp_pkg.sv
hdl/branch_decode.sv
hdl/predictor_bank.sv
hdl/next_pc_select.sv
hdl/branch_predictor.sv
dv/bp_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing \
  --top-module bp_tb \
  -f all.f \
  -o bp_sim

./obj_dir/bp_sim | tee "$log"

if grep -q "Regression failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

echo "simulation finished without failure"
exit 0
